//--- include/link_params.svh
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// --------------------------------------------------
// Orbit and BX numbering
// --------------------------------------------------

// Width of the BX number
`define BX_WIDTH           12

// BX that carries the trailer
`define BX_TRAILER         12'd3555

// Reserved BX range with commas only
`define BX_RESERVED_FIRST  12'd3556
`define BX_RESERVED_LAST   12'd3559

// Last BX of the LHC orbit
`define BX_LAST            12'd3563

// --------------------------------------------------
// Frame and link widths
// --------------------------------------------------

// Payload words per crossing
`define WORDS_PER_BX       3
`define WORD_WIDTH         64

// 32-bit link words per crossing
`define LINK_WORDS_PER_BX  6
`define LINK_DATA_WIDTH    32
`define LINK_K_WIDTH       4

`define LINK_ID_WIDTH      20

// --------------------------------------------------
// 8b10b character codes
// --------------------------------------------------

// K28.5 in the lowest byte
`define TX_COMMA           32'h505050bc
`define TX_COMMA_K         4'b0001

// K23.7 in all four bytes
`define TX_PADDING         32'hf7f7f7f7
`define TX_PADDING_K       4'hf

// Trailer CRC slot
`define TX_CRC             32'h0

`endif

//--- hw/link_frame_pkg.sv
package link_frame_pkg;

    `include "link_params.svh"

    // One BX worth of payload from upstream
    // Word 0 goes out first
    typedef struct packed {
        logic                                     bc0;
        logic [`WORDS_PER_BX-1:0][`WORD_WIDTH-1:0] words;
    } payload_frame_t;

    // Payload after trailer and reserved substitution
    // One charisk bit per data byte
    typedef struct packed {
        logic [`WORDS_PER_BX-1:0][`WORD_WIDTH-1:0]   data;
        logic [`WORDS_PER_BX-1:0][`WORD_WIDTH/8-1:0] charisk;
    } formatted_frame_t;

    // Word handed to the transceiver each cycle
    typedef struct packed {
        logic [`LINK_DATA_WIDTH-1:0] data;
        logic [`LINK_K_WIDTH-1:0]    charisk;
    } link_word_t;

endpackage

//--- hw/link_ctrl_pkg.sv
package link_ctrl_pkg;

    // Content class of the current crossing
    typedef enum logic [1:0] {
        REGION_PAYLOAD  = 2'd0,
        REGION_TRAILER  = 2'd1,
        REGION_RESERVED = 2'd2
    } bx_region_e;

    // Serializer FSM
    typedef enum logic {
        SER_IDLE    = 1'b0,
        SER_SENDING = 1'b1
    } ser_state_e;

endpackage

//--- hw/bx_counter.sv
`timescale 1ns/1ps

`include "link_params.svh"

module bx_counter
    import link_ctrl_pkg::*;
(
    input  logic                 gt0_rxusrclk_i,
    input  logic                 gt0_rxresetdone_i,
    input  logic                 advance_i,
    input  logic                 bc0_i,
    input  logic [`BX_WIDTH-1:0] bx_offset_i,
    output bx_region_e           bx_region_o
);

    logic [`BX_WIDTH-1:0] bx;

    // One step per accepted frame
    always_ff @(posedge gt0_rxusrclk_i or negedge gt0_rxresetdone_i)
    begin
        if (!gt0_rxresetdone_i)
            bx <= '0;
        else if (advance_i)
        begin
            // BC0 resyncs to the programmed offset
            if (bc0_i)
                bx <= bx_offset_i;
            else if (bx == `BX_LAST)
                bx <= '0;
            else
                bx <= bx + 1'b1;
        end
    end

    // Region of the BX being accepted now
    always_comb
    begin
        if (bx == `BX_TRAILER)
            bx_region_o = REGION_TRAILER;
        else if (bx >= `BX_RESERVED_FIRST && bx <= `BX_RESERVED_LAST)
            bx_region_o = REGION_RESERVED;
        else
            bx_region_o = REGION_PAYLOAD;
    end

endmodule

//--- hw/frame_formatter.sv
`timescale 1ns/1ps

`include "link_params.svh"

module frame_formatter
    import link_frame_pkg::*;
    import link_ctrl_pkg::*;
(
    input  logic                      gt0_rxusrclk_i,
    input  logic                      gt0_rxresetdone_i,
    // Upstream handshake
    input  logic                      frame_valid_i,
    input  payload_frame_t            frame_i,
    output logic                      frame_ready_o,
    // Static configuration
    input  logic [`LINK_ID_WIDTH-1:0] link_id_i,
    // BX counter side
    input  bx_region_e                bx_region_i,
    output logic                      advance_o,
    output logic                      bc0_o,
    // Serializer handshake
    output logic                      fmt_valid_o,
    output formatted_frame_t          fmt_frame_o,
    input  logic                      fmt_ready_i
);

    logic                        accept;
    logic [`LINK_DATA_WIDTH-1:0] link_id_word;
    formatted_frame_t            fmt_next;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------

    // Room when empty or when the held frame leaves now
    assign frame_ready_o = !fmt_valid_o || fmt_ready_i;
    assign accept        = frame_valid_i && frame_ready_o;

    // Counter steps with every accepted frame
    assign advance_o = accept;
    assign bc0_o     = frame_i.bc0;

    // --------------------------------------------------
    // Content selection
    // --------------------------------------------------

    // Link id split in two 10-bit halves
    assign link_id_word = {6'h0, link_id_i[9:0], 6'h0, link_id_i[19:10]};

    always_comb
    begin
        // Default payload with no K characters
        fmt_next.data    = frame_i.words;
        fmt_next.charisk = '0;
        case (bx_region_i)
            REGION_TRAILER:
            begin
                // CRC over comma
                fmt_next.data[0]    = {`TX_CRC, `TX_COMMA};
                fmt_next.charisk[0] = {4'b0000, `TX_COMMA_K};
                // Comma over link id
                fmt_next.data[1]    = {`TX_COMMA, link_id_word};
                fmt_next.charisk[1] = {`TX_COMMA_K, 4'b0000};
                // Comma pair
                fmt_next.data[2]    = {`TX_COMMA, `TX_COMMA};
                fmt_next.charisk[2] = {`TX_COMMA_K, `TX_COMMA_K};
            end
            REGION_RESERVED:
            begin
                // Payload discarded here
                for (int i = 0; i < `WORDS_PER_BX; i++)
                begin
                    fmt_next.data[i]    = {`TX_COMMA, `TX_COMMA};
                    fmt_next.charisk[i] = {`TX_COMMA_K, `TX_COMMA_K};
                end
            end
            default:
            begin
                fmt_next.data    = frame_i.words;
                fmt_next.charisk = '0;
            end
        endcase
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    always_ff @(posedge gt0_rxusrclk_i or negedge gt0_rxresetdone_i)
    begin
        if (!gt0_rxresetdone_i)
            fmt_valid_o <= 1'b0;
        else if (accept)
            fmt_valid_o <= 1'b1;
        else if (fmt_ready_i)
            fmt_valid_o <= 1'b0;
    end

    // Held while the serializer is busy
    always_ff @(posedge gt0_rxusrclk_i)
    begin
        if (accept)
            fmt_frame_o <= fmt_next;
    end

endmodule

//--- hw/word_serializer.sv
`timescale 1ns/1ps

`include "link_params.svh"

module word_serializer
    import link_frame_pkg::*;
    import link_ctrl_pkg::*;
(
    input  logic             gt0_rxusrclk_i,
    input  logic             gt0_rxresetdone_i,
    // Formatter handshake
    input  logic             fmt_valid_i,
    input  formatted_frame_t fmt_frame_i,
    output logic             fmt_ready_o,
    // Transceiver data
    output link_word_t       link_word_o
);

    localparam int IDX_W = $clog2(`LINK_WORDS_PER_BX);

    ser_state_e              state;
    logic [IDX_W-1:0]        word_idx;
    logic                    last_word;
    logic                    take;
    formatted_frame_t        frame_q;
    logic [1:0]              word_sel;
    logic [`WORD_WIDTH-1:0]  cur_word;
    logic [`WORD_WIDTH/8-1:0] cur_k;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------

    assign last_word = (word_idx == IDX_W'(`LINK_WORDS_PER_BX - 1));

    // Next frame may follow the sixth word directly
    assign fmt_ready_o = (state == SER_IDLE) || last_word;
    assign take        = fmt_valid_i && fmt_ready_o;

    always_ff @(posedge gt0_rxusrclk_i or negedge gt0_rxresetdone_i)
    begin
        if (!gt0_rxresetdone_i)
        begin
            state    <= SER_IDLE;
            word_idx <= '0;
        end
        else if (take)
        begin
            state    <= SER_SENDING;
            word_idx <= '0;
        end
        else if (state == SER_SENDING)
        begin
            if (last_word)
            begin
                // Nothing queued so fall back to padding
                state    <= SER_IDLE;
                word_idx <= '0;
            end
            else
                word_idx <= word_idx + 1'b1;
        end
    end

    // Frame buffer
    always_ff @(posedge gt0_rxusrclk_i)
    begin
        if (take)
            frame_q <= fmt_frame_i;
    end

    // --------------------------------------------------
    // Word select
    // --------------------------------------------------

    // Two link words per 64-bit word
    assign word_sel = word_idx[2:1];
    assign cur_word = frame_q.data[word_sel];
    assign cur_k    = frame_q.charisk[word_sel];

    always_comb
    begin
        if (state == SER_IDLE)
        begin
            link_word_o.data    = `TX_PADDING;
            link_word_o.charisk = `TX_PADDING_K;
        end
        else if (word_idx[0])
        begin
            // Upper half second
            link_word_o.data    = cur_word[63:32];
            link_word_o.charisk = cur_k[7:4];
        end
        else
        begin
            link_word_o.data    = cur_word[31:0];
            link_word_o.charisk = cur_k[3:0];
        end
    end

endmodule

//--- hw/link_tx_top.sv
`timescale 1ns/1ps

`include "link_params.svh"

module link_tx_top
    import link_frame_pkg::*;
    import link_ctrl_pkg::*;
(
    input  logic                      gt0_rxusrclk_i,
    input  logic                      gt0_rxresetdone_i,
    input  logic                      frame_valid_i,
    input  payload_frame_t            frame_i,
    output logic                      frame_ready_o,
    input  logic [`LINK_ID_WIDTH-1:0] link_id_i,
    input  logic [`BX_WIDTH-1:0]      bx_offset_i,
    output link_word_t                link_word_o
);

    // Counter to formatter
    logic             advance;
    logic             bc0;
    bx_region_e       bx_region;

    // Formatter to serializer
    logic             fmt_valid;
    formatted_frame_t fmt_frame;
    logic             ser_ready;

    // --------------------------------------------------
    // Orbit position
    // --------------------------------------------------

    bx_counter bx_counter_i
    (
        .gt0_rxusrclk_i    (gt0_rxusrclk_i),
        .gt0_rxresetdone_i (gt0_rxresetdone_i),
        .advance_i         (advance),
        .bc0_i             (bc0),
        .bx_offset_i       (bx_offset_i),
        .bx_region_o       (bx_region)
    );

    // --------------------------------------------------
    // Formatting and serialization
    // --------------------------------------------------

    frame_formatter frame_formatter_i
    (
        .gt0_rxusrclk_i    (gt0_rxusrclk_i),
        .gt0_rxresetdone_i (gt0_rxresetdone_i),
        .frame_valid_i     (frame_valid_i),
        .frame_i           (frame_i),
        .frame_ready_o     (frame_ready_o),
        .link_id_i         (link_id_i),
        .bx_region_i       (bx_region),
        .advance_o         (advance),
        .bc0_o             (bc0),
        .fmt_valid_o       (fmt_valid),
        .fmt_frame_o       (fmt_frame),
        .fmt_ready_i       (ser_ready)
    );

    // Six link words per crossing
    word_serializer word_serializer_i
    (
        .gt0_rxusrclk_i    (gt0_rxusrclk_i),
        .gt0_rxresetdone_i (gt0_rxresetdone_i),
        .fmt_valid_i       (fmt_valid),
        .fmt_frame_i       (fmt_frame),
        .fmt_ready_o       (ser_ready),
        .link_word_o       (link_word_o)
    );

endmodule

//--- verification/link_tx_tb.sv
`timescale 1ns/1ps

`include "link_params.svh"

module link_tx_tb
    import link_frame_pkg::*;
();

    localparam int MAX_TESTS    = 32;
    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 50;

    logic                      gt0_rxusrclk_i;
    logic                      gt0_rxresetdone_i;
    logic                      frame_valid_i;
    payload_frame_t            frame_i;
    logic                      frame_ready_o;
    logic [`LINK_ID_WIDTH-1:0] link_id_i;
    logic [`BX_WIDTH-1:0]      bx_offset_i;
    link_word_t                link_word_o;

    // Test table loaded from the data file
    logic [127:0] test_name  [MAX_TESTS];
    logic         test_gap   [MAX_TESTS];
    logic         test_bc0   [MAX_TESTS];
    logic [63:0]  test_words [MAX_TESTS][`WORDS_PER_BX];
    logic [31:0]  exp_data   [MAX_TESTS][`LINK_WORDS_PER_BX];
    logic [3:0]   exp_k      [MAX_TESTS][`LINK_WORDS_PER_BX];
    int           num_tests    = 0;

    // Monitor bookkeeping
    int           frames_seen  = 0;
    int           word_cnt     = 0;
    int           errors       = 0;
    int           tests_failed = 0;
    logic         test_bad     = 1'b0;

    // Main process bookkeeping
    int           other_errors  = 0;
    int           gap_tests     = 0;
    int           cycle_limit   = 0;
    int           cycles        = 0;
    logic         running       = 1'b0;
    logic         ready_dropped = 1'b0;
    logic         load_ok;
    logic [7:0]   lfsr          = 8'd78;

    link_tx_top link_tx_top_i
    (
        .gt0_rxusrclk_i    (gt0_rxusrclk_i),
        .gt0_rxresetdone_i (gt0_rxresetdone_i),
        .frame_valid_i     (frame_valid_i),
        .frame_i           (frame_i),
        .frame_ready_o     (frame_ready_o),
        .link_id_i         (link_id_i),
        .bx_offset_i       (bx_offset_i),
        .link_word_o       (link_word_o)
    );

    // 50 MHz link clock
    initial
    begin
        gt0_rxusrclk_i = 1'b0;
        forever
            #(CLK_HALF) gt0_rxusrclk_i = ~gt0_rxusrclk_i;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // Galois LFSR with taps x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        if (state[0])
            return (state >> 1) ^ 8'hb8;
        return state >> 1;
    endfunction

    // One LFSR step per gap bit
    task automatic draw_gap(output logic [2:0] len);
        len = '0;
        for (int b = 0; b < 3; b++)
        begin
            len  = {len[1:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1)
            c = $fgetc(fd);
    endtask

    task automatic load_tests(output logic ok);
        int           fd;
        int           r;
        int           n;
        logic [127:0] key;
        logic [127:0] name;
        logic [3:0]   gap;
        logic [3:0]   bc0;
        logic [63:0]  w0;
        logic [63:0]  w1;
        logic [63:0]  w2;
        logic [31:0]  d;
        logic [3:0]   k;
        logic [19:0]  id;
        logic [11:0]  ofs;
        ok = 1'b0;
        n  = 0;
        fd = $fopen("verification/link_tx_tests.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", key) == 1)
            begin
                if (key == "#")
                    skip_line(fd);
                else if (key == "cfg")
                begin
                    r = $fscanf(fd, "%h %h", id, ofs);
                    if (r != 2)
                        ok = 1'b0;
                    link_id_i   = id;
                    bx_offset_i = ofs;
                end
                else if (key == "frame" && n < MAX_TESTS)
                begin
                    r = $fscanf(fd, "%s %h %h %h %h %h", name, gap, bc0, w0, w1, w2);
                    if (r != 6)
                        ok = 1'b0;
                    test_name[n]     = name;
                    test_gap[n]      = gap[0];
                    test_bc0[n]      = bc0[0];
                    test_words[n][0] = w0;
                    test_words[n][1] = w1;
                    test_words[n][2] = w2;
                    n++;
                end
                else if (key == "expect" && n > 0)
                begin
                    // Expected words belong to the last frame read
                    for (int i = 0; i < `LINK_WORDS_PER_BX; i++)
                    begin
                        r = $fscanf(fd, "%h %h", d, k);
                        if (r != 2)
                            ok = 1'b0;
                        exp_data[n-1][i] = d;
                        exp_k[n-1][i]    = k;
                    end
                end
                else
                begin
                    $display("Unknown record in the tests file");
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
        num_tests = n;
        if (n == 0)
            ok = 1'b0;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    task automatic drive_tests();
        logic [2:0] gap_len;
        logic       rdy;
        for (int t = 0; t < num_tests; t++)
        begin
            gap_len = '0;
            if (test_gap[t])
                draw_gap(gap_len);
            if (gap_len != 0)
            begin
                frame_valid_i <= 1'b0;
                repeat (gap_len)
                    @(posedge gt0_rxusrclk_i);
            end
            frame_valid_i    <= 1'b1;
            frame_i.bc0      <= test_bc0[t];
            frame_i.words[0] <= test_words[t][0];
            frame_i.words[1] <= test_words[t][1];
            frame_i.words[2] <= test_words[t][2];
            // Ready sampled mid-cycle with the transfer on the next edge
            rdy = 1'b0;
            while (!rdy)
            begin
                @(negedge gt0_rxusrclk_i);
                rdy = frame_ready_o;
                if (!rdy)
                    ready_dropped = 1'b1;
                @(posedge gt0_rxusrclk_i);
            end
        end
        frame_valid_i <= 1'b0;
    endtask

    // --------------------------------------------------
    // Output monitor
    // --------------------------------------------------

    always @(negedge gt0_rxusrclk_i)
    begin
        if (running)
        begin
            if (link_word_o.data == `TX_PADDING && link_word_o.charisk == `TX_PADDING_K)
            begin
                // Padding only between frames and never inside one
                if (frames_seen < num_tests && word_cnt != 0)
                begin
                    $display("Padding appeared inside frame %0s", test_name[frames_seen]);
                    test_bad = 1'b1;
                    errors++;
                end
                // Back-to-back frames leave no idle slot
                else if (frames_seen > 0 && frames_seen < num_tests && !test_gap[frames_seen])
                begin
                    $display("Padding sent with frame %0s already queued",
                             test_name[frames_seen]);
                    test_bad = 1'b1;
                    errors++;
                end
            end
            else if (frames_seen >= num_tests)
            begin
                $display("Unexpected link word %h after the last frame", link_word_o.data);
                errors++;
            end
            else
            begin
                if (link_word_o.data !== exp_data[frames_seen][word_cnt] ||
                    link_word_o.charisk !== exp_k[frames_seen][word_cnt])
                begin
                    $display("ERR %0s word %0d expected %h/%h actual %h/%h",
                             test_name[frames_seen], word_cnt,
                             exp_data[frames_seen][word_cnt], exp_k[frames_seen][word_cnt],
                             link_word_o.data, link_word_o.charisk);
                    test_bad = 1'b1;
                    errors++;
                end
                if (word_cnt == `LINK_WORDS_PER_BX - 1)
                begin
                    if (test_bad)
                    begin
                        $display("FAIL %0s", test_name[frames_seen]);
                        tests_failed++;
                    end
                    else
                        $display("PASS %0s", test_name[frames_seen]);
                    test_bad = 1'b0;
                    word_cnt = 0;
                    frames_seen++;
                end
                else
                    word_cnt++;
            end
        end
    end

    // Stall guard
    always @(posedge gt0_rxusrclk_i)
    begin
        if (running)
        begin
            cycles = cycles + 1;
            if (cycles > cycle_limit)
            begin
                $display("Output stalled, %0d of %0d frames seen after %0d cycles",
                         frames_seen, num_tests, cycles);
                $display("Test failed");
                $finish;
            end
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial
    begin
        gt0_rxresetdone_i = 1'b0;
        frame_valid_i     = 1'b0;
        frame_i           = '0;
        link_id_i         = '0;
        bx_offset_i       = '0;
        load_tests(load_ok);
        if (!load_ok)
        begin
            $display("Could not read verification/link_tx_tests.txt");
            $display("Test failed");
            $finish;
        end
        else
        begin
            for (int t = 0; t < num_tests; t++)
            begin
                if (test_gap[t])
                    gap_tests++;
            end
            // Six words per frame plus the longest gaps
            cycle_limit = num_tests * `LINK_WORDS_PER_BX + gap_tests * 7 + MARGIN;
            repeat (RESET_CYCLES)
                @(posedge gt0_rxusrclk_i);
            gt0_rxresetdone_i <= 1'b1;
            @(negedge gt0_rxusrclk_i);
            if (!frame_ready_o)
            begin
                $display("frame_ready_o is low after reset");
                other_errors++;
            end
            running = 1'b1;
            @(posedge gt0_rxusrclk_i);
            drive_tests();
            wait (frames_seen == num_tests);
            // Watch for duplicated frames
            repeat (8)
                @(negedge gt0_rxusrclk_i);
            running = 1'b0;
            if (!ready_dropped)
            begin
                $display("frame_ready_o never went low under continuous input");
                other_errors++;
            end
            $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                     num_tests, num_tests - tests_failed, tests_failed,
                     errors + other_errors);
            if (errors + other_errors == 0 && tests_failed == 0)
                $display("Test passed");
            else
                $display("Test failed");
            $finish;
        end
    end

endmodule

//--- verification/link_tx_tests.txt
# cfg line holds the link id and the BX offset in hex
# frame lines hold name, gap flag, bc0 and payload words 0 1 2 in hex
# expect lines hold six link words as data charisk pairs, word 0 low half first
cfg 5a3c1 de1
frame pay_bc0 0 1 0100aaaa0100bbbb 0110aaaa0110bbbb 0120aaaa0120bbbb
expect 0100bbbb 0 0100aaaa 0 0110bbbb 0 0110aaaa 0 0120bbbb 0 0120aaaa 0
frame pay_3553 1 0 0200aaaa0200bbbb 0210aaaa0210bbbb 0220aaaa0220bbbb
expect 0200bbbb 0 0200aaaa 0 0210bbbb 0 0210aaaa 0 0220bbbb 0 0220aaaa 0
frame pay_3554 0 0 0300aaaa0300bbbb 0310aaaa0310bbbb 0320aaaa0320bbbb
expect 0300bbbb 0 0300aaaa 0 0310bbbb 0 0310aaaa 0 0320bbbb 0 0320aaaa 0
frame trailer_3555 0 0 0400aaaa0400bbbb 0410aaaa0410bbbb 0420aaaa0420bbbb
expect 505050bc 1 00000000 0 03c10168 0 505050bc 1 505050bc 1 505050bc 1
frame rsv_3556 0 0 0500aaaa0500bbbb 0510aaaa0510bbbb 0520aaaa0520bbbb
expect 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1
frame rsv_3557 0 0 0600aaaa0600bbbb 0610aaaa0610bbbb 0620aaaa0620bbbb
expect 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1
frame rsv_3558 0 0 0700aaaa0700bbbb 0710aaaa0710bbbb 0720aaaa0720bbbb
expect 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1
frame rsv_3559 0 0 0800aaaa0800bbbb 0810aaaa0810bbbb 0820aaaa0820bbbb
expect 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1 505050bc 1
frame pay_3560 1 0 0900aaaa0900bbbb 0910aaaa0910bbbb 0920aaaa0920bbbb
expect 0900bbbb 0 0900aaaa 0 0910bbbb 0 0910aaaa 0 0920bbbb 0 0920aaaa 0
frame pay_3561 0 0 1000aaaa1000bbbb 1010aaaa1010bbbb 1020aaaa1020bbbb
expect 1000bbbb 0 1000aaaa 0 1010bbbb 0 1010aaaa 0 1020bbbb 0 1020aaaa 0
frame pay_3562 1 0 1100aaaa1100bbbb 1110aaaa1110bbbb 1120aaaa1120bbbb
expect 1100bbbb 0 1100aaaa 0 1110bbbb 0 1110aaaa 0 1120bbbb 0 1120aaaa 0
frame pay_3563 0 0 1200aaaa1200bbbb 1210aaaa1210bbbb 1220aaaa1220bbbb
expect 1200bbbb 0 1200aaaa 0 1210bbbb 0 1210aaaa 0 1220bbbb 0 1220aaaa 0
frame pay_wrap_0 1 0 1300aaaa1300bbbb 1310aaaa1310bbbb 1320aaaa1320bbbb
expect 1300bbbb 0 1300aaaa 0 1310bbbb 0 1310aaaa 0 1320bbbb 0 1320aaaa 0
frame pay_1 0 0 1400aaaa1400bbbb 1410aaaa1410bbbb 1420aaaa1420bbbb
expect 1400bbbb 0 1400aaaa 0 1410bbbb 0 1410aaaa 0 1420bbbb 0 1420aaaa 0

//--- flist.f
+incdir+include
hw/link_frame_pkg.sv
hw/link_ctrl_pkg.sv
hw/bx_counter.sv
hw/frame_formatter.sv
hw/word_serializer.sv
hw/link_tx_top.sv
verification/link_tx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= link_tx_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
